/* fxp_mul_pkg.sv */
// ======================================================================
// shared definitions for the fixed-point multiply unit
// operand width, request/result types, control state encoding
// ======================================================================
`default_nettype none

package fxp_mul_pkg;

  // ====================================================================
  // widths
  // ====================================================================
  localparam int FXP_WIDTH = 32;                 // operand and result width
  localparam int STEP_BITS = $clog2(FXP_WIDTH);  // one step per multiplier bit

  // ====================================================================
  // payload types
  // ====================================================================

  // one fixed-point word, signed or unsigned depending on the unit
  typedef logic [FXP_WIDTH-1:0] fxp_t;

  // request payload, c = a * b
  typedef struct packed {
    fxp_t a;  // multiplicand
    fxp_t b;  // multiplier
  } mul_req_t;

  // ====================================================================
  // control
  // ====================================================================
  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for a request, operands tracked
    CALC = 2'd1,  // shift-and-add steps
    DONE = 2'd2   // result held for the consumer
  } mul_state_e;

endpackage

`default_nettype wire

/* step_counter.sv */
// ======================================================================
// step counter for the shift-and-add multiplier
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module step_counter (
  input  logic clk,
  input  logic reset,
  input  logic count_en,     // advance one step
  input  logic count_clear,  // back to step zero
  output logic last_step     // count sits on the final multiplier bit
);
  import fxp_mul_pkg::*;

  localparam logic [STEP_BITS-1:0] LAST_COUNT = STEP_BITS'(FXP_WIDTH - 1);

  logic [STEP_BITS-1:0] count;

  // clear wins over enable
  always_ff @(posedge clk) begin
    if (reset || count_clear) begin
      count <= '0;
    end else if (count_en) begin
      count <= count + 1'b1;
    end
  end

  // terminal step decode, so the FSM never looks at the count itself
  assign last_step = (count == LAST_COUNT);

endmodule

`default_nettype wire

/* mul_control.sv */
// ======================================================================
// control FSM for the multiply unit
// idle / calc / done, handshake and datapath strobes
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module mul_control (
  input  logic clk,
  input  logic reset,

  // request side
  input  logic recv_val,
  output logic recv_rdy,

  // result side
  output logic send_val,
  input  logic send_rdy,

  // step counter
  input  logic last_step,
  output logic count_en,
  output logic count_clear,

  // datapath strobes
  output logic load,
  output logic add_en,
  output logic last_step_corr
);
  import fxp_mul_pkg::*;

  mul_state_e state;
  mul_state_e state_next;

  // ====================================================================
  // state register
  // ====================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ====================================================================
  // next state
  // ====================================================================
  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (recv_val) state_next = CALC;   // recv_rdy is high here
      CALC: if (last_step) state_next = DONE;
      DONE: if (send_rdy) state_next = IDLE;   // result taken
      default: state_next = IDLE;
    endcase
  end

  // ====================================================================
  // outputs, decoded from state only (plus last_step)
  // ====================================================================
  always_comb begin
    recv_rdy       = 1'b0;
    send_val       = 1'b0;
    count_en       = 1'b0;
    count_clear    = 1'b0;
    load           = 1'b0;
    add_en         = 1'b0;
    last_step_corr = 1'b0;
    case (state)
      IDLE: begin
        recv_rdy = 1'b1;
        load     = 1'b1;  // operands captured every idle cycle
      end
      CALC: begin
        count_en       = 1'b1;
        add_en         = 1'b1;
        last_step_corr = last_step;  // sign bit of the multiplier
      end
      DONE: begin
        send_val    = 1'b1;
        count_clear = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* mul_datapath.sv */
// ======================================================================
// shift-and-add datapath for the fixed-point multiply unit
// operand shift registers, accumulator, sign correction, result slice
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module mul_datapath #(
  parameter int frac_bits   = 16,  // fraction bits of the Q format
  parameter int signed_mode = 1    // 1 for two's complement operands
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,            // capture operands, zero acc
  input  logic                   add_en,          // one multiply step
  input  logic                   last_step_corr,  // step on the multiplier msb
  input  fxp_mul_pkg::mul_req_t  req,
  output fxp_mul_pkg::fxp_t      c
);
  import fxp_mul_pkg::*;

  // only the low ACC_W bits of the full product are ever needed
  localparam int ACC_W = FXP_WIDTH + frac_bits;

  logic [ACC_W-1:0]     mcand;     // multiplicand, shifts left
  logic [FXP_WIDTH-1:0] mplier;    // multiplier, shifts right
  logic [ACC_W-1:0]     acc;       // partial product
  logic [ACC_W-1:0]     acc_next;

  logic a_sign;     // fill bit for the multiplicand extension
  logic do_sub;     // msb of a signed multiplier weighs -2^(n-1)
  logic take_bit;   // current multiplier bit is set

  // ====================================================================
  // operand preparation
  // ====================================================================
  assign a_sign   = (signed_mode != 0) && req.a[FXP_WIDTH-1];
  assign do_sub   = last_step_corr && (signed_mode != 0);
  assign take_bit = add_en && mplier[0];

  // ====================================================================
  // operand shift registers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{frac_bits{a_sign}}, req.a};
      mplier <= req.b;
    end else if (add_en) begin
      mcand  <= mcand << 1;   // weight of the next multiplier bit
      mplier <= mplier >> 1;
    end
  end

  // ====================================================================
  // accumulator
  // ====================================================================
  always_comb begin
    acc_next = acc;
    if (take_bit) begin
      if (do_sub) begin
        acc_next = acc - mcand;  // negative weight of the sign bit
      end else begin
        acc_next = acc + mcand;
      end
    end
  end

  // held at zero while waiting, so each product starts clean
  always_ff @(posedge clk) begin
    if (reset || load) begin
      acc <= '0;
    end else begin
      acc <= acc_next;
    end
  end

  // ====================================================================
  // result
  // ====================================================================

  // drop the extra fraction bits, floor and wrap come for free
  assign c = acc[ACC_W-1:frac_bits];

endmodule

`default_nettype wire

/* fxp_mul_unit.sv */
// ======================================================================
// fixed-point multiply unit, top level
// control FSM, step counter and shift-and-add datapath
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module fxp_mul_unit #(
  parameter int frac_bits   = 16,  // Q16.16 by default
  parameter int signed_mode = 1    // 0 for unsigned operands
) (
  input  logic                   clk,
  input  logic                   reset,

  // request port
  input  logic                   recv_val,
  output logic                   recv_rdy,
  input  fxp_mul_pkg::mul_req_t  req,

  // result port
  output logic                   send_val,
  input  logic                   send_rdy,
  output fxp_mul_pkg::fxp_t      c
);

  // control to counter
  logic count_en;
  logic count_clear;
  logic last_step;

  // control to datapath
  logic load;
  logic add_en;
  logic last_step_corr;

  // ====================================================================
  // control
  // ====================================================================
  mul_control u_control (
    .clk            (clk),
    .reset          (reset),
    .recv_val       (recv_val),
    .recv_rdy       (recv_rdy),
    .send_val       (send_val),
    .send_rdy       (send_rdy),
    .last_step      (last_step),
    .count_en       (count_en),
    .count_clear    (count_clear),
    .load           (load),
    .add_en         (add_en),
    .last_step_corr (last_step_corr)
  );

  step_counter u_counter (
    .clk         (clk),
    .reset       (reset),
    .count_en    (count_en),
    .count_clear (count_clear),
    .last_step   (last_step)
  );

  // ====================================================================
  // datapath
  // ====================================================================
  mul_datapath #(
    .frac_bits   (frac_bits),
    .signed_mode (signed_mode)
  ) u_datapath (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .add_en         (add_en),
    .last_step_corr (last_step_corr),
    .req            (req),
    .c              (c)
  );

endmodule

`default_nettype wire

/* fxp_mul_assert.sv */
// ======================================================================
// handshake, stability and latency assertions for the multiply unit
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module fxp_mul_assert (
  input logic                     clk,
  input logic                     reset,
  input logic                     recv_val,
  input logic                     recv_rdy,
  input logic                     send_val,
  input logic                     send_rdy,
  input fxp_mul_pkg::fxp_t        c
);
  import fxp_mul_pkg::*;

  int error_count = 0;  // failures seen so far

  // request and result side never open together
  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(recv_rdy && send_val))
    else begin
      error_count++;
      $error("recv_rdy and send_val high in the same cycle");
    end

  // result held while the consumer stalls
  a_hold_result: assert property (@(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && $stable(c)))
    else begin
      error_count++;
      $error("result or send_val changed during back-pressure");
    end

  // one step per multiplier bit, then the result
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (recv_val && recv_rdy) |=> (!send_val [*FXP_WIDTH] ##1 send_val))
    else begin
      error_count++;
      $error("send_val did not rise %0d cycles after accept", FXP_WIDTH);
    end

endmodule

bind fxp_mul_unit fxp_mul_assert u_assert (
  .clk      (clk),
  .reset    (reset),
  .recv_val (recv_val),
  .recv_rdy (recv_rdy),
  .send_val (send_val),
  .send_rdy (send_rdy),
  .c        (c)
);

`default_nettype wire

/* tb_fxp_mul_unit.sv */
// ======================================================================
// testbench for the fixed-point multiply unit
// directed patterns from file, random products, back-pressure, latency
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_fxp_mul_unit;
  import fxp_mul_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int FRAC            = 16;
  localparam int N_PATTERNS      = 24;
  localparam int N_RANDOM        = 200;
  localparam int N_BACK          = 16;
  localparam int MAX_STALL       = 20;
  localparam int N_PRODUCTS      = N_PATTERNS + N_RANDOM + N_BACK;
  localparam int WATCHDOG_CYCLES = N_PRODUCTS * (FXP_WIDTH + 40) + RESET_CYCLES;

  logic     clk;
  logic     reset;
  logic     recv_val;
  logic     recv_rdy;
  mul_req_t req;
  logic     send_val;
  logic     send_rdy;
  fxp_t     c;

  logic [31:0] pat_mem [0:3*N_PATTERNS-1];  // a, b, expected c per product

  fxp_mul_unit #(
    .frac_bits   (FRAC),
    .signed_mode (1)
  ) u_fxp_mul_unit (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .req      (req),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .c        (c)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================================================================
  // helpers
  // ====================================================================
  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("Something failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // 64-bit signed product, floor shift by the fraction, low word kept
  function automatic fxp_t expected_product(input fxp_t a, input fxp_t b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] product;
    wide_a  = {{32{a[31]}}, a};
    wide_b  = {{32{b[31]}}, b};
    product = wide_a * wide_b;
    product = product >>> FRAC;
    return product[31:0];
  endfunction

  // called at a falling edge, returns at the one before the accepting edge
  task automatic start_request(input fxp_t a, input fxp_t b);
    int waited;
    waited   = 0;
    recv_val = 1'b1;
    req.a    = a;
    req.b    = b;
    while (!recv_rdy && waited < 4 * FXP_WIDTH) begin
      @(negedge clk);
      waited++;
    end
    check_value("recv_rdy", recv_rdy, 1'b1);
  endtask

  task automatic wait_result(input fxp_t expected, input int stall, input bit keep_val);
    int   latency;
    int   i;
    fxp_t held;
    latency = 0;
    @(negedge clk);  // low phase right after the accepting edge
    if (!keep_val) begin
      recv_val = 1'b0;
    end
    send_rdy = 1'b0;
    while (!send_val && latency <= FXP_WIDTH + 4) begin
      latency++;
      @(negedge clk);
    end
    check_value("latency", latency, FXP_WIDTH);
    check_value("c", c, expected);
    held = c;
    // consumer stalls, a competing request is offered meanwhile
    for (i = 0; i < stall; i++) begin
      if (i == 0 && !keep_val) begin
        recv_val = 1'b1;
        req.a    = $urandom();
        req.b    = $urandom();
      end
      @(negedge clk);
      check_value("send_val", send_val, 1'b1);
      check_value("recv_rdy", recv_rdy, 1'b0);
      check_value("c", c, held);
    end
    send_rdy = 1'b1;  // take the result on the next edge
    if (!keep_val) begin
      recv_val = 1'b0;
    end
    @(negedge clk);
    send_rdy = 1'b0;
    check_value("send_val", send_val, 1'b0);
    check_value("recv_rdy", recv_rdy, 1'b1);  // idle again one cycle later
  endtask

  task automatic run_product(input fxp_t a, input fxp_t b, input fxp_t expected,
                             input int stall, input bit keep_val);
    start_request(a, b);
    wait_result(expected, stall, keep_val);
  endtask

  // ====================================================================
  // watchdog
  // ====================================================================
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: no progress after %0d cycles, the run was stopped", WATCHDOG_CYCLES);
    $display("Something failed");
    $fatal(1, "run timed out");
  end

  // bound checker failures end the run at once
  always @(posedge clk) begin
    if (u_fxp_mul_unit.u_assert.error_count != 0) begin
      $display("assertion failure reported by the multiply unit checker");
      $display("Something failed");
      $fatal(1, "assertion failed");
    end
  end

  // ====================================================================
  // stimulus
  // ====================================================================
  initial begin : main
    int   i;
    int   stall;
    fxp_t a;
    fxp_t b;
    void'($urandom(32'h656f099f));
    reset     = 1'b1;
    recv_val  = 1'b0;
    req       = '0;
    send_rdy  = 1'b0;
    $readmemh("mul_patterns.hex", pat_mem);
    if ($isunknown(pat_mem[3*N_PATTERNS-1])) begin
      $display("could not read all patterns from mul_patterns.hex");
      $display("Something failed");
      $fatal(1, "pattern file missing or short");
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("recv_rdy", recv_rdy, 1'b1);
    check_value("send_val", send_val, 1'b0);

    // directed products from the pattern file
    for (i = 0; i < N_PATTERNS; i++) begin
      run_product(pat_mem[3*i], pat_mem[3*i+1], pat_mem[3*i+2], 0, 1'b0);
    end

    // random operands with random consumer stalls
    for (i = 0; i < N_RANDOM; i++) begin
      a     = $urandom();
      b     = $urandom();
      stall = $urandom_range(MAX_STALL, 0);
      run_product(a, b, expected_product(a, b), stall, 1'b0);
    end

    // recv_val held high across results
    for (i = 0; i < N_BACK; i++) begin
      a = $urandom();
      b = $urandom();
      run_product(a, b, expected_product(a, b), 0, 1'b1);
    end
    recv_val = 1'b0;
    repeat (4) @(negedge clk);

    if (u_fxp_mul_unit.u_assert.error_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("%0d assertion failures in the multiply unit",
               u_fxp_mul_unit.u_assert.error_count);
      $display("Something failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

/* mul_patterns.hex */
// columns: a b expected_c, Q16.16 two's complement in hex
// expected_c = floor(a * b / 2^16), low 32 bits kept
00000000 00000000 00000000
00010000 00010000 00010000
00000000 00010000 00000000
00010000 FFFF0000 FFFF0000
FFFF0000 FFFF0000 00010000
00020000 00030000 00060000
00008000 00008000 00004000
00018000 FFFE0000 FFFD0000
FFFD8000 FFFC0000 000A0000
00000001 00000001 00000000
FFFFFFFF 00000001 FFFFFFFF
FFFFFFFF FFFFFFFF 00000000
00010000 00000001 00000001
FFFF0000 00000001 FFFFFFFF
80000000 00010000 80000000
80000000 FFFF0000 80000000
80000000 80000000 00000000
7FFFFFFF 7FFFFFFF FFFF0000
01000000 01000000 00000000
00C80000 00C80000 9C400000
00034000 0000C000 00027000
FFFF4000 00034000 FFFD9000
FFFFFFFF 00008000 FFFFFFFF
12345678 00010000 12345678

/* list.f */
fxp_mul_pkg.sv
step_counter.sv
mul_control.sv
mul_datapath.sv
fxp_mul_unit.sv
fxp_mul_assert.sv
tb_fxp_mul_unit.sv
